/* video_tx_pkg.sv */
package video_tx_pkg;

	// ========================================================================
	// link speed
	// ========================================================================

	// same encoding as the PHY status bits, 10 Mb is the slowest
	typedef enum logic [1:0] {
		SPEED_10   = 2'b01,
		SPEED_100  = 2'b10,
		SPEED_1000 = 2'b11
	} link_speed_t;

	// ========================================================================
	// ethernet framing
	// ========================================================================

	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam int PREAMBLE_LEN = 7;
	localparam logic [7:0] SFD_BYTE = 8'hD5;
	localparam int IFG_BYTES = 12; // idle byte-times after the crc

	// frame id, segment number, copy index, length
	localparam int HEADER_LEN = 4;

	localparam logic [31:0] CRC_POLY = 32'hEDB88320; // reflected 802.3 poly
	localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

	// clock cycles per byte on the wire
	function automatic int pace_divisor(link_speed_t speed);
		case (speed)
			SPEED_10:  return 100;
			SPEED_100: return 10;
			default:   return 1;
		endcase
	endfunction

endpackage

/* pixel_store.sv */
`timescale 1ns/1ps

module pixel_store #(
	parameter int FRAME_PIXELS = 64
) (
	input  logic clk125MHz,
	input  logic reset,
	input  logic frame_start,
	input  logic pixel_valid,
	input  logic [7:0] pixel_r,
	input  logic [7:0] pixel_g,
	input  logic [7:0] pixel_b,
	input  logic busy,
	input  logic [$clog2(3 * FRAME_PIXELS) - 1:0] rd_addr,
	output logic [7:0] rd_data,
	output logic frame_ready
);

	localparam int MEM_BYTES = 3 * FRAME_PIXELS;
	localparam int ADDR_W = $clog2(MEM_BYTES);
	localparam int PIX_W = $clog2(FRAME_PIXELS + 1);

	typedef enum logic {
		ST_IDLE,
		ST_CAPTURE
	} state_t;

	state_t state;
	logic [1:0] ser_phase; // 0 waits for a pixel, 1 writes green, 2 writes blue
	logic [7:0] pix_g;
	logic [7:0] pix_b;
	logic [ADDR_W - 1:0] wr_addr;
	logic [PIX_W - 1:0] pixel_count;
	logic wr_en;
	logic [7:0] wr_data;
	logic [7:0] mem [0:MEM_BYTES - 1];

	// byte serializer, red goes straight from the port
	always_comb begin
		wr_en = 1'b0;
		wr_data = pixel_r;
		if (state == ST_CAPTURE) begin
			if (ser_phase == 2'd0) begin
				wr_en = pixel_valid;
			end else begin
				wr_en = 1'b1;
				wr_data = (ser_phase == 2'd1) ? pix_g : pix_b;
			end
		end
	end

	// ========================================================================
	// capture FSM
	// ========================================================================
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			state <= ST_IDLE;
			ser_phase <= 2'd0;
			wr_addr <= '0;
			pixel_count <= '0;
			frame_ready <= 1'b0;
		end else begin
			frame_ready <= 1'b0;
			if (wr_en)
				wr_addr <= wr_addr + 1'b1;
			case (state)
				ST_IDLE: begin
					// frame memory is in use while the sequencer is busy
					if (frame_start && !busy) begin
						state <= ST_CAPTURE;
						wr_addr <= '0;
						pixel_count <= '0;
						ser_phase <= 2'd0;
					end
				end
				ST_CAPTURE: begin
					if (ser_phase == 2'd0) begin
						if (pixel_valid)
							ser_phase <= 2'd1;
					end else if (ser_phase == 2'd1) begin
						ser_phase <= 2'd2;
					end else begin
						ser_phase <= 2'd0;
						pixel_count <= pixel_count + 1'b1;
						if (pixel_count == PIX_W'(FRAME_PIXELS - 1)) begin
							state <= ST_IDLE;
							frame_ready <= 1'b1; // last byte written this cycle
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// held green and blue while red is written
	always_ff @(posedge clk125MHz) begin
		if (state == ST_CAPTURE && ser_phase == 2'd0 && pixel_valid) begin
			pix_g <= pixel_g;
			pix_b <= pixel_b;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr]; // registered read port
	end

endmodule

/* segment_sequencer.sv */
`timescale 1ns/1ps

module segment_sequencer #(
	parameter int FRAME_PIXELS = 64,
	parameter int SEGMENT_BYTES = 64
) (
	input  logic clk125MHz,
	input  logic reset,
	input  logic frame_ready,
	input  logic [2:0] redundancy,
	input  logic packet_done,
	output logic start_segment,
	output logic [7:0] segment_num,
	output logic [2:0] copy_index,
	output logic [7:0] frame_id,
	output logic busy
);

	localparam int NUM_SEGMENTS = 3 * FRAME_PIXELS / SEGMENT_BYTES;

	typedef enum logic [1:0] {
		SQ_IDLE,
		SQ_ISSUE,
		SQ_WAIT
	} state_t;

	state_t state;
	logic [2:0] copies; // copies per segment for the current frame

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			state <= SQ_IDLE;
			copies <= 3'd1;
			start_segment <= 1'b0;
			segment_num <= 8'd0;
			copy_index <= 3'd0;
			frame_id <= 8'd0;
			busy <= 1'b0;
		end else begin
			start_segment <= 1'b0;
			case (state)
				SQ_IDLE: begin
					if (frame_ready) begin
						busy <= 1'b1;
						frame_id <= frame_id + 8'd1; // first frame goes out as id 1
						copies <= (redundancy == 3'd0) ? 3'd1 : redundancy;
						segment_num <= 8'd0;
						copy_index <= 3'd0;
						state <= SQ_ISSUE;
					end
				end
				SQ_ISSUE: begin
					start_segment <= 1'b1;
					state <= SQ_WAIT;
				end
				SQ_WAIT: begin
					if (packet_done) begin
						if (copy_index != copies - 3'd1) begin
							copy_index <= copy_index + 3'd1; // next copy, same segment
							state <= SQ_ISSUE;
						end else if (segment_num != 8'(NUM_SEGMENTS - 1)) begin
							copy_index <= 3'd0;
							segment_num <= segment_num + 8'd1;
							state <= SQ_ISSUE;
						end else begin
							// whole frame is out
							copy_index <= 3'd0;
							busy <= 1'b0;
							state <= SQ_IDLE;
						end
					end
				end
				default: state <= SQ_IDLE;
			endcase
		end
	end

endmodule

/* frame_packetizer.sv */
`timescale 1ns/1ps

module frame_packetizer
	import video_tx_pkg::*;
#(
	parameter int FRAME_PIXELS = 64,
	parameter int SEGMENT_BYTES = 64
) (
	input  logic clk125MHz,
	input  logic reset,
	input  logic start_segment,
	input  logic [7:0] segment_num,
	input  logic [2:0] copy_index,
	input  logic [7:0] frame_id,
	input  logic advance,
	input  logic [7:0] rd_data,
	output logic [$clog2(3 * FRAME_PIXELS) - 1:0] rd_addr,
	output logic [7:0] pkt_byte,
	output logic pkt_last,
	output logic pkt_start
);

	localparam int ADDR_W = $clog2(3 * FRAME_PIXELS);
	localparam int PKT_LEN = HEADER_LEN + SEGMENT_BYTES;
	localparam int IDX_W = $clog2(PKT_LEN);
	localparam logic [IDX_W - 1:0] LAST_IDX = IDX_W'(PKT_LEN - 1);

	logic [7:0] hdr_frame_id;
	logic [7:0] hdr_segment;
	logic [7:0] hdr_copy;
	logic [IDX_W - 1:0] req_idx; // byte most recently requested
	logic [IDX_W - 1:0] out_idx; // byte on pkt_byte, one cycle behind req_idx
	logic req_ok;

	// the final byte stays on the output once it is reached
	assign req_ok = advance && (req_idx != LAST_IDX);

	// ========================================================================
	// byte index pipeline
	// ========================================================================
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			req_idx <= '0;
			out_idx <= '0;
			pkt_start <= 1'b0;
		end else begin
			pkt_start <= start_segment; // framer begins once the header is latched
			out_idx <= req_idx; // lines up with rd_data
			if (start_segment)
				req_idx <= '0;
			else if (req_ok)
				req_idx <= req_idx + 1'b1;
		end
	end

	// header fields and payload address
	always_ff @(posedge clk125MHz) begin
		if (start_segment) begin
			hdr_frame_id <= frame_id;
			hdr_segment <= segment_num;
			hdr_copy <= {5'd0, copy_index};
			rd_addr <= ADDR_W'(int'(segment_num) * SEGMENT_BYTES);
		end else if (req_ok && req_idx >= IDX_W'(HEADER_LEN)) begin
			// base address is already prefetched for the first payload byte
			rd_addr <= rd_addr + 1'b1;
		end
	end

	always_comb begin
		case (out_idx)
			IDX_W'(0): pkt_byte = hdr_frame_id;
			IDX_W'(1): pkt_byte = hdr_segment;
			IDX_W'(2): pkt_byte = hdr_copy;
			IDX_W'(3): pkt_byte = 8'(SEGMENT_BYTES); // length, low byte
			default:   pkt_byte = rd_data;
		endcase
	end

	assign pkt_last = (out_idx == LAST_IDX);

endmodule

/* mac_tx_framer.sv */
`timescale 1ns/1ps

module mac_tx_framer
	import video_tx_pkg::*;
(
	input  logic clk125MHz,
	input  logic reset,
	input  link_speed_t speed,
	input  logic pkt_start,
	input  logic [7:0] pkt_byte,
	input  logic pkt_last,
	output logic advance,
	output logic [7:0] tx_data,
	output logic tx_en,
	output logic tx_strobe,
	output logic packet_done
);

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_PREAMBLE,
		PH_SFD,
		PH_DATA,
		PH_CRC,
		PH_GAP
	} phase_t;

	phase_t phase;
	logic [6:0] pace_div; // byte period, fixed for the whole packet
	logic [6:0] pace_cnt;
	logic tick; // byte slot
	logic first_data;
	logic [3:0] byte_cnt;
	logic [31:0] crc;

	function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
		input logic [7:0] data);
		logic [31:0] c;
		c = crc_in ^ {24'd0, data};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
		end
		return c;
	endfunction

	assign tick = (phase != PH_IDLE) && (pace_cnt == 7'd0);

	// request the byte two cycles ahead of the slot that sends it
	// at 1000 Mb every cycle is a slot, so requests run ahead from the SFD on
	always_comb begin
		if (pace_div == 7'd1)
			advance = (phase == PH_SFD) || (phase == PH_DATA);
		else
			advance = (phase == PH_DATA) && !first_data && (pace_cnt == 7'd2);
	end

	// ========================================================================
	// phase FSM and pacing
	// ========================================================================
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			phase <= PH_IDLE;
			pace_div <= 7'd1;
			pace_cnt <= 7'd0;
			first_data <= 1'b0;
			byte_cnt <= 4'd0;
			tx_data <= 8'h00;
			tx_en <= 1'b0;
			tx_strobe <= 1'b0;
			packet_done <= 1'b0;
		end else begin
			tx_strobe <= 1'b0;
			packet_done <= 1'b0;
			if (phase == PH_IDLE) begin
				if (pkt_start) begin
					pace_div <= 7'(pace_divisor(speed));
					pace_cnt <= 7'd0; // first slot right away
					byte_cnt <= 4'd0;
					phase <= PH_PREAMBLE;
				end
			end else if (tick) begin
				pace_cnt <= pace_div - 7'd1;
				case (phase)
					PH_PREAMBLE: begin
						tx_data <= PREAMBLE_BYTE;
						tx_en <= 1'b1;
						tx_strobe <= 1'b1;
						if (byte_cnt == 4'(PREAMBLE_LEN - 1)) begin
							byte_cnt <= 4'd0;
							phase <= PH_SFD;
						end else begin
							byte_cnt <= byte_cnt + 4'd1;
						end
					end
					PH_SFD: begin
						tx_data <= SFD_BYTE;
						tx_strobe <= 1'b1;
						first_data <= 1'b1;
						phase <= PH_DATA;
					end
					PH_DATA: begin
						tx_data <= pkt_byte;
						tx_strobe <= 1'b1;
						first_data <= 1'b0;
						if (pkt_last)
							phase <= PH_CRC;
					end
					PH_CRC: begin
						tx_data <= ~crc[7:0]; // fcs goes out lsb first
						tx_strobe <= 1'b1;
						if (byte_cnt == 4'd3) begin
							byte_cnt <= 4'd0;
							phase <= PH_GAP;
						end else begin
							byte_cnt <= byte_cnt + 4'd1;
						end
					end
					PH_GAP: begin
						tx_en <= 1'b0; // first gap slot ends the last crc byte
						if (byte_cnt == 4'(IFG_BYTES)) begin
							byte_cnt <= 4'd0;
							packet_done <= 1'b1;
							phase <= PH_IDLE;
						end else begin
							byte_cnt <= byte_cnt + 4'd1;
						end
					end
					default: phase <= PH_IDLE;
				endcase
			end else begin
				pace_cnt <= pace_cnt - 7'd1;
			end
		end
	end

	// crc over header and payload, shifted out during the crc phase
	always_ff @(posedge clk125MHz) begin
		if (tick) begin
			case (phase)
				PH_SFD:  crc <= CRC_INIT;
				PH_DATA: crc <= crc32_byte(crc, pkt_byte);
				PH_CRC:  crc <= {8'h00, crc[31:8]};
				default: crc <= crc;
			endcase
		end
	end

endmodule

/* video_eth_tx_top.sv */
`timescale 1ns/1ps

module video_eth_tx_top
	import video_tx_pkg::*;
#(
	parameter int FRAME_PIXELS = 64,
	parameter int SEGMENT_BYTES = 64 // must divide 3 * FRAME_PIXELS
) (
	input  logic clk125MHz,
	input  logic reset,
	input  logic frame_start,
	input  logic pixel_valid,
	input  logic [7:0] pixel_r,
	input  logic [7:0] pixel_g,
	input  logic [7:0] pixel_b,
	input  logic [2:0] redundancy,
	input  logic link_10mb,
	input  logic link_100mb,
	input  logic link_1000mb,
	output logic [7:0] tx_data,
	output logic tx_en,
	output logic tx_strobe,
	output logic busy
);

	localparam int ADDR_W = $clog2(3 * FRAME_PIXELS);

	link_speed_t speed;
	logic frame_ready;
	logic start_segment;
	logic packet_done;
	logic advance;
	logic pkt_start;
	logic pkt_last;
	logic [7:0] segment_num;
	logic [7:0] frame_id;
	logic [7:0] rd_data;
	logic [7:0] pkt_byte;
	logic [2:0] copy_index;
	logic [ADDR_W - 1:0] rd_addr;

	// fastest link wins, last choice kept while the link is down
	always_ff @(posedge clk125MHz) begin
		if (reset)
			speed <= SPEED_1000;
		else if (link_1000mb)
			speed <= SPEED_1000;
		else if (link_100mb)
			speed <= SPEED_100;
		else if (link_10mb)
			speed <= SPEED_10;
	end

	// ========================================================================
	// datapath
	// ========================================================================
	pixel_store #(
		.FRAME_PIXELS(FRAME_PIXELS)
	) pixel_store_i (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.frame_start(frame_start),
		.pixel_valid(pixel_valid),
		.pixel_r(pixel_r),
		.pixel_g(pixel_g),
		.pixel_b(pixel_b),
		.busy(busy),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.frame_ready(frame_ready)
	);

	segment_sequencer #(
		.FRAME_PIXELS(FRAME_PIXELS),
		.SEGMENT_BYTES(SEGMENT_BYTES)
	) segment_sequencer_i (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.frame_ready(frame_ready),
		.redundancy(redundancy),
		.packet_done(packet_done),
		.start_segment(start_segment),
		.segment_num(segment_num),
		.copy_index(copy_index),
		.frame_id(frame_id),
		.busy(busy)
	);

	frame_packetizer #(
		.FRAME_PIXELS(FRAME_PIXELS),
		.SEGMENT_BYTES(SEGMENT_BYTES)
	) frame_packetizer_i (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.start_segment(start_segment),
		.segment_num(segment_num),
		.copy_index(copy_index),
		.frame_id(frame_id),
		.advance(advance),
		.rd_data(rd_data),
		.rd_addr(rd_addr),
		.pkt_byte(pkt_byte),
		.pkt_last(pkt_last),
		.pkt_start(pkt_start)
	);

	mac_tx_framer mac_tx_framer_i (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.speed(speed),
		.pkt_start(pkt_start),
		.pkt_byte(pkt_byte),
		.pkt_last(pkt_last),
		.advance(advance),
		.tx_data(tx_data),
		.tx_en(tx_en),
		.tx_strobe(tx_strobe),
		.packet_done(packet_done)
	);

endmodule

/* video_eth_tx_assert.sv */
`timescale 1ns/1ps

module video_eth_tx_assert
	import video_tx_pkg::*;
(
	input logic clk125MHz,
	input logic reset,
	input link_speed_t speed,
	input logic pkt_start,
	input logic start_segment,
	input logic packet_done,
	input logic tx_en,
	input logic tx_strobe,
	input logic busy
);

	int unsigned fail_count = 0;
	logic [7:0] pace_q; // byte period latched like the framer does
	logic [7:0] since_strobe;
	logic strobe_seen;
	logic in_flight;

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			pace_q <= 8'd1;
			since_strobe <= 8'd0;
			strobe_seen <= 1'b0;
			in_flight <= 1'b0;
		end else begin
			if (pkt_start)
				pace_q <= 8'(pace_divisor(speed));
			if (tx_strobe)
				since_strobe <= 8'd1;
			else if (since_strobe != 8'hFF)
				since_strobe <= since_strobe + 8'd1; // saturates in long gaps
			if (tx_strobe)
				strobe_seen <= 1'b1;
			else if (!tx_en)
				strobe_seen <= 1'b0;
			if (start_segment)
				in_flight <= 1'b1;
			else if (packet_done)
				in_flight <= 1'b0;
		end
	end

	// ========================================================================
	// protocol checks
	// ========================================================================
	idle_after_reset: assert property (@(posedge clk125MHz)
		reset |=> !tx_en && !tx_strobe && !busy)
		else begin
			fail_count++;
			$error("tx_en, tx_strobe or busy high right after reset");
		end

	strobe_spacing: assert property (@(posedge clk125MHz) disable iff (reset)
		tx_strobe && strobe_seen |-> since_strobe == pace_q)
		else begin
			fail_count++;
			$error("tx_strobe spacing %0d, framer pace %0d", since_strobe, pace_q);
		end

	strobe_inside_en: assert property (@(posedge clk125MHz) disable iff (reset)
		tx_strobe |-> tx_en)
		else begin
			fail_count++;
			$error("tx_strobe pulse outside tx_en");
		end

	one_packet_at_a_time: assert property (@(posedge clk125MHz) disable iff (reset)
		start_segment |-> !in_flight)
		else begin
			fail_count++;
			$error("start_segment issued while a packet is still in flight");
		end

endmodule

bind video_eth_tx_top video_eth_tx_assert video_eth_tx_assert_i (
	.clk125MHz(clk125MHz),
	.reset(reset),
	.speed(speed),
	.pkt_start(pkt_start),
	.start_segment(start_segment),
	.packet_done(packet_done),
	.tx_en(tx_en),
	.tx_strobe(tx_strobe),
	.busy(busy)
);

/* tb_video_eth_tx.sv */
`timescale 1ns/1ps

module tb_video_eth_tx
	import video_tx_pkg::*;
();

	localparam int FRAME_PIXELS = 64;
	localparam int SEGMENT_BYTES = 64;
	localparam int NUM_SEGMENTS = 3 * FRAME_PIXELS / SEGMENT_BYTES;
	localparam int WIRE_BYTES = PREAMBLE_LEN + 1 + HEADER_LEN + SEGMENT_BYTES + 4;

	logic clk125MHz = 1'b0;
	logic reset = 1'b1;
	logic frame_start = 1'b0;
	logic pixel_valid = 1'b0;
	logic [7:0] pixel_r = 8'h00;
	logic [7:0] pixel_g = 8'h00;
	logic [7:0] pixel_b = 8'h00;
	logic [2:0] redundancy = 3'd0;
	logic link_10mb = 1'b0;
	logic link_100mb = 1'b0;
	logic link_1000mb = 1'b1;
	logic [7:0] tx_data;
	logic tx_en;
	logic tx_strobe;
	logic busy;

	logic [31:0] lfsr = 32'ha40e_3817;
	logic [7:0] frame_bytes [0:3 * FRAME_PIXELS - 1]; // stored frame in r g b order
	logic [7:0] pkt_bytes [$];
	int errors = 0;
	int exp_frame_id = 0;
	int exp_seg = 0;
	int exp_copy = 0;
	int exp_copies = 1;
	int exp_pace = 1;
	int pkt_count = 0;
	int strobe_gap = 0;
	int low_cycles = 0;
	bit en_q = 1'b0;
	bit first_frame_done = 1'b0;
	bit timed_out = 1'b0;

	video_eth_tx_top #(
		.FRAME_PIXELS(FRAME_PIXELS),
		.SEGMENT_BYTES(SEGMENT_BYTES)
	) video_eth_tx_top_i (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.frame_start(frame_start),
		.pixel_valid(pixel_valid),
		.pixel_r(pixel_r),
		.pixel_g(pixel_g),
		.pixel_b(pixel_b),
		.redundancy(redundancy),
		.link_10mb(link_10mb),
		.link_100mb(link_100mb),
		.link_1000mb(link_1000mb),
		.tx_data(tx_data),
		.tx_en(tx_en),
		.tx_strobe(tx_strobe),
		.busy(busy)
	);

	initial begin
		forever #4 clk125MHz = ~clk125MHz;
	end

	// taps for x^32 + x^22 + x^2 + x + 1 with new bits entering at the lsb
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output logic [7:0] value);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[6:0], lfsr[0]};
		end
	endtask

	// bit-serial crc over one data byte
	function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] b);
		logic [31:0] c;
		logic fb;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			fb = c[0] ^ b[i];
			c = c >> 1;
			if (fb)
				c = c ^ CRC_POLY;
		end
		return c;
	endfunction

	task automatic finish_run();
		int assert_fails;
		assert_fails = video_eth_tx_top_i.video_eth_tx_assert_i.fail_count;
		$display("errors: %0d testbench, %0d bound assertions", errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int cnt;
		cnt = 0;
		while (busy !== level && cnt < limit) begin
			@(posedge clk125MHz);
			#1;
			cnt++;
		end
		if (busy !== level) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: busy did not go to %b within %0d cycles", level, limit);
		end
	endtask

	// ========================================================================
	// expected packet from the stored frame
	// ========================================================================
	task automatic check_packet();
		logic [7:0] exp_q [$];
		logic [31:0] crc;
		logic [7:0] data;
		bit bad;
		int n;
		exp_q = {};
		for (int i = 0; i < PREAMBLE_LEN; i++)
			exp_q.push_back(PREAMBLE_BYTE);
		exp_q.push_back(SFD_BYTE);
		crc = CRC_INIT;
		for (int i = 0; i < HEADER_LEN + SEGMENT_BYTES; i++) begin
			case (i)
				0: data = 8'(exp_frame_id);
				1: data = 8'(exp_seg);
				2: data = 8'(exp_copy);
				3: data = 8'(SEGMENT_BYTES);
				default: data = frame_bytes[exp_seg * SEGMENT_BYTES + i - HEADER_LEN];
			endcase
			exp_q.push_back(data);
			crc = crc_update(crc, data);
		end
		crc = ~crc;
		for (int i = 0; i < 4; i++)
			exp_q.push_back(crc[8 * i +: 8]); // fcs lsb first
		assert (pkt_bytes.size() == exp_q.size()) else begin
			errors++;
			$display("FAIL %0t packet length got %0d expected %0d", $time,
				pkt_bytes.size(), exp_q.size());
		end
		n = (pkt_bytes.size() < exp_q.size()) ? pkt_bytes.size() : exp_q.size();
		bad = 1'b0;
		for (int i = 0; i < n && !bad; i++) begin
			assert (pkt_bytes[i] == exp_q[i]) else begin
				errors++;
				bad = 1'b1; // first mismatch is enough per packet
				$display("FAIL %0t tx_data[%0d] got %h expected %h", $time, i,
					pkt_bytes[i], exp_q[i]);
			end
		end
		pkt_count++;
		exp_copy++;
		if (exp_copy == exp_copies) begin
			exp_copy = 0;
			exp_seg++;
		end
	endtask

	// wire-side capture of the DUT outputs at each clock edge
	always @(posedge clk125MHz) begin
		if (reset) begin
			en_q = 1'b0;
			strobe_gap = 0;
			low_cycles = 0;
		end else begin
			if (tx_en && !en_q) begin
				if (pkt_count > 0) begin // gap between packets of one frame
					assert (low_cycles >= IFG_BYTES * exp_pace) else begin
						errors++;
						$display("FAIL %0t tx_en low cycles got %0d expected >= %0d",
							$time, low_cycles, IFG_BYTES * exp_pace);
					end
				end
				pkt_bytes.delete();
			end
			if (tx_strobe) begin
				if (pkt_bytes.size() > 0) begin
					assert (strobe_gap == exp_pace) else begin
						errors++;
						$display("FAIL %0t tx_strobe spacing got %0d expected %0d",
							$time, strobe_gap, exp_pace);
					end
				end
				pkt_bytes.push_back(tx_data);
				strobe_gap = 0;
			end
			if (!tx_en && en_q) begin
				check_packet();
				low_cycles = 0;
			end
			strobe_gap++;
			if (!tx_en)
				low_cycles++;
			en_q = tx_en;
		end
	end

	idle_before_frame: assert property (@(posedge clk125MHz) disable iff (reset)
		!first_frame_done |-> !busy && !tx_en && !tx_strobe)
		else begin
			errors++;
			$display("FAIL %0t busy=%b tx_en=%b tx_strobe=%b expected 0 before a frame",
				$time, busy, tx_en, tx_strobe);
		end

	// one pixel every 3 cycles and the expected frame updated only when keep is set
	task automatic offer_frame(input bit keep);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		frame_start = 1'b1;
		@(posedge clk125MHz);
		#1;
		frame_start = 1'b0;
		for (int p = 0; p < FRAME_PIXELS; p++) begin
			random_byte(r);
			random_byte(g);
			random_byte(b);
			pixel_r = r;
			pixel_g = g;
			pixel_b = b;
			pixel_valid = 1'b1;
			if (keep) begin
				frame_bytes[3 * p] = r;
				frame_bytes[3 * p + 1] = g;
				frame_bytes[3 * p + 2] = b;
			end
			@(posedge clk125MHz);
			#1;
			pixel_valid = 1'b0;
			repeat (2) @(posedge clk125MHz);
			#1;
		end
	endtask

	task automatic run_frame(input int red, input logic [2:0] links, input int pace,
		input bit offer_while_busy);
		int limit;
		if (timed_out)
			return;
		{link_1000mb, link_100mb, link_10mb} = links;
		redundancy = 3'(red);
		exp_frame_id++;
		exp_seg = 0;
		exp_copy = 0;
		exp_copies = (red == 0) ? 1 : red;
		exp_pace = pace;
		pkt_count = 0;
		offer_frame(1'b1);
		first_frame_done = 1'b1;
		wait_busy(1'b1, 50);
		if (timed_out)
			return;
		if (offer_while_busy)
			offer_frame(1'b0); // must be dropped
		limit = NUM_SEGMENTS * exp_copies * ((WIRE_BYTES + IFG_BYTES + 2) * pace + 20);
		wait_busy(1'b0, limit);
		if (timed_out)
			return;
		assert (pkt_count == NUM_SEGMENTS * exp_copies && exp_seg == NUM_SEGMENTS)
		else begin
			errors++;
			$display("FAIL %0t packet count got %0d expected %0d", $time, pkt_count,
				NUM_SEGMENTS * exp_copies);
		end
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin
		repeat (16) @(posedge clk125MHz);
		#1;
		reset = 1'b0;
		repeat (10) @(posedge clk125MHz);
		#1;
		run_frame(0, 3'b100, 1, 1'b1);
		run_frame(3, 3'b010, 10, 1'b0);
		run_frame(7, 3'b001, 100, 1'b0);
		run_frame(0, 3'b000, 100, 1'b0); // all links down so the 10 Mb choice stays
		repeat (20) @(posedge clk125MHz);
		finish_run();
	end

endmodule

/* filelist.f */
video_tx_pkg.sv
pixel_store.sv
segment_sequencer.sv
frame_packetizer.sv
mac_tx_framer.sv
video_eth_tx_top.sv
video_eth_tx_assert.sv
tb_video_eth_tx.sv

/* Bender.yml */
package:
  name: video_eth_tx

sources:
  - video_tx_pkg.sv
  - pixel_store.sv
  - segment_sequencer.sv
  - frame_packetizer.sv
  - mac_tx_framer.sv
  - video_eth_tx_top.sv
  - target: test
    files:
      - video_eth_tx_assert.sv
      - tb_video_eth_tx.sv
